/* verilog.f */
+incdir+design
design/mm_pkg.sv
design/mm_vector_ram.sv
design/mm_multiplier.sv
design/mm_lane_accum.sv
design/mm_row_reduce.sv
design/mm_control.sv
design/mm_top.sv
testbench/tb_mm_assertions.sv
testbench/tb_mm.sv

/* Makefile */
# Verilator build and run of the matrix-vector kernel testbench

VERILATOR ?= verilator
TOP       ?= tb_mm
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard design/*.sv design/*.svh testbench/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* testbench/tb_mm.sv */
`timescale 1ns/1ps
`include "mm_macros.svh"

module tb_mm;

  localparam int SW     = `MM_SIMD_WIDTH;
  localparam int WORD_W = `MM_SIMD_WIDTH * `MM_W_D;
  // stream words and commands over all tests, zero commands included
  localparam int TOTAL_WORDS = 16 + (9 + 12 + 15) + (20 + 12) + (7 + 5);
  localparam int TOTAL_CMDS  = 12;
  localparam int CYCLE_LIMIT = 2 * (4 * TOTAL_WORDS + TOTAL_CMDS * `MM_DRAIN);

  logic               CLK;
  logic               RST;
  mm_pkg::a_write_t   a_write;
  logic               cmd_req;
  mm_pkg::lane_t      cmd_data;
  logic               cmd_ack;
  logic               b_valid;
  mm_pkg::simd_word_u b_data;
  logic               b_deq;
  logic               c_valid;
  mm_pkg::simd_word_u c_data;
  logic               rsp_req;
  mm_pkg::lane_t      rsp_data;
  logic               rsp_ack;

  integer             seed;
  int                 stall_pct;        // chance of b_valid low, percent
  string              test_name;
  int                 cycles = 0;
  mm_pkg::simd_word_u stream_q [$];     // words not yet dequeued
  mm_pkg::simd_word_u exp_q [$];        // expected output words
  int                 row_q [$];        // row sums waiting to be packed
  int                 vec [0:(1<<`MM_W_A)-1];
  int                 row_words;
  int                 model_pos;        // word index inside the row
  int                 model_sum;
  int                 replies = 0;
  int                 rsp_rises = 0;
  int                 words_seen = 0;
  logic               rsp_q = 1'b0;
  logic               first_reply;
  mm_pkg::lane_t      last_reply;

  mm_top DUT (
    .CLK (CLK), .RST (RST), .a_write (a_write),
    .cmd_req (cmd_req), .cmd_data (cmd_data), .cmd_ack (cmd_ack),
    .b_valid (b_valid), .b_data (b_data), .b_deq (b_deq),
    .c_valid (c_valid), .c_data (c_data),
    .rsp_req (rsp_req), .rsp_data (rsp_data), .rsp_ack (rsp_ack)
  );

  bind mm_top tb_mm_assertions u_handshake_checks (
    .CLK (CLK), .RST (RST), .cmd_req (cmd_req), .cmd_ack (cmd_ack),
    .rsp_req (rsp_req), .rsp_ack (rsp_ack), .b_valid (b_valid),
    .b_deq (b_deq), .c_valid (c_valid)
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;  // 8 ns period
  end

  // --------------------
  // error reporting
  // --------------------
  task automatic stop_with_failure();
    $display("TB FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic report_mismatch(input string what, input logic [WORD_W-1:0] exp,
                                 input logic [WORD_W-1:0] act);
    $display("** Error [%s] %s: expected %h, actual %h", test_name, what, exp, act);
    stop_with_failure();
  endtask

  task automatic report_problem(input string what);
    $display("in test %s: %s", test_name, what);
    stop_with_failure();
  endtask

  always @(posedge CLK) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      report_problem($sformatf("timeout, run not over after %0d cycles", CYCLE_LIMIT));
    end
  end

  // --------------------
  // reference model
  // --------------------
  function automatic void model_word(input mm_pkg::simd_word_u w);
    mm_pkg::simd_word_u packed_rows;
    for (int j = 0; j < SW; j++) begin
      model_sum += w.lanes[j] * vec[model_pos*SW + j];  // wraps at 32 bits
    end
    model_pos++;
    if (model_pos == row_words) begin
      row_q.push_back(model_sum);
      model_sum = 0;
      model_pos = 0;
      if (row_q.size() == SW) begin
        for (int k = 0; k < SW; k++) begin
          packed_rows.lanes[k] = row_q[k];  // oldest row in lane 0
        end
        exp_q.push_back(packed_rows);
        row_q.delete();
      end
    end
  endfunction

  // --------------------
  // stream source and monitors
  // --------------------
  task automatic stream_source();
    logic deq_seen;
    int   roll;
    forever begin
      @(negedge CLK);
      deq_seen = b_deq;
      @(posedge CLK);
      #1;
      if (deq_seen) begin
        b_data = stream_q.pop_front();  // word follows its dequeue
      end
      roll    = int'($unsigned($random(seed)) % 100);
      b_valid = (stream_q.size() > 0) && (roll >= stall_pct);
    end
  endtask

  initial stream_source();

  always @(negedge CLK) begin
    rsp_q <= rsp_req;
    if (!RST && rsp_req && !rsp_q) begin
      rsp_rises <= rsp_rises + 1;  // one per reply
    end
    if (!RST && c_valid) begin
      assert (exp_q.size() > 0) else report_problem("output word arrived with none expected");
      if (exp_q.size() > 0) begin
        words_seen++;
        assert (c_data == exp_q[0]) else report_mismatch("output word", exp_q[0], c_data);
        void'(exp_q.pop_front());
      end
    end
  end

  // --------------------
  // handshakes
  // --------------------
  task automatic send_command(input int value);
    @(posedge CLK);
    #1;
    cmd_data = value;
    cmd_req  = 1'b1;
    do @(negedge CLK); while (!cmd_ack);
    @(posedge CLK);
    #1;
    cmd_req = 1'b0;
    do @(negedge CLK); while (cmd_ack);  // four-phase close
  endtask

  task automatic take_reply();
    mm_pkg::lane_t reply;
    do @(negedge CLK); while (!rsp_req);
    reply = rsp_data;
    if (!first_reply) begin
      assert ($unsigned(reply) > $unsigned(last_reply))
        else report_problem($sformatf("reply %0d not above previous %0d", reply, last_reply));
    end
    first_reply = 1'b0;
    last_reply  = reply;
    replies++;
    @(posedge CLK);
    #1;
    rsp_ack = 1'b1;
    do @(negedge CLK); while (rsp_req);
    @(posedge CLK);
    #1;
    rsp_ack = 1'b0;
  endtask

  task automatic start_matrix(input int size);
    mm_pkg::a_write_t wr;
    for (int e = 0; e < size; e++) begin
      vec[e] = $random(seed);
    end
    for (int a = 0; a < size / SW; a++) begin
      @(posedge CLK);
      #1;
      wr.we   = 1'b1;
      wr.addr = (`MM_W_A-`MM_LOG_SIMD)'(a);
      for (int j = 0; j < SW; j++) begin
        wr.data.lanes[j] = vec[a*SW + j];
      end
      a_write = wr;
    end
    @(posedge CLK);
    #1;
    a_write.we  = 1'b0;
    row_words   = size / SW;
    model_pos   = 0;
    model_sum   = 0;
    first_reply = 1'b1;  // cycle count restarts
    send_command(size);
  endtask

  task automatic run_computation(input int n_words);
    mm_pkg::simd_word_u w;
    for (int i = 0; i < n_words; i++) begin
      for (int j = 0; j < SW; j++) begin
        w.lanes[j] = $random(seed);
      end
      stream_q.push_back(w);
      model_word(w);
    end
    send_command(n_words);
    take_reply();
  endtask

  task automatic end_matrix();
    int rises_before;
    rises_before = rsp_rises;
    send_command(0);
    repeat (`MM_DRAIN + 6) @(negedge CLK);  // room for a stray reply
    assert (rsp_rises == rises_before) else report_problem("zero command gave a reply");
    assert (exp_q.size() == 0)
      else report_problem($sformatf("%0d output words never arrived", exp_q.size()));
  endtask

  // --------------------
  // test sequence
  // --------------------
  initial begin
    seed      = 1676;
    stall_pct = 0;
    test_name = "reset";
    RST       = 1'b1;
    a_write   = '0;
    cmd_req   = 1'b0;
    cmd_data  = '0;
    b_valid   = 1'b0;
    b_data    = '0;
    rsp_ack   = 1'b0;
    repeat (10) @(posedge CLK);
    #1;
    RST = 1'b0;

    test_name = "idle_after_reset";
    repeat (5) begin
      @(negedge CLK);
      assert (!cmd_ack && !rsp_req && !b_deq && !c_valid)
        else report_problem("handshake or output active before the first command");
    end

    test_name = "single_computation";
    start_matrix(8);
    run_computation(16);  // 4 rows
    end_matrix();
    assert (words_seen == 2) else report_mismatch("output word count", 2, words_seen);

    test_name = "multi_command";  // rows straddle command borders
    start_matrix(12);
    run_computation(9);
    run_computation(12);
    run_computation(15);
    end_matrix();

    test_name = "stream_stalls";
    stall_pct = 40;
    start_matrix(16);
    run_computation(20);
    run_computation(12);
    end_matrix();

    test_name = "new_vector";
    start_matrix(6);
    run_computation(7);
    run_computation(5);
    end_matrix();

    assert (rsp_rises == replies) else report_mismatch("reply count", replies, rsp_rises);
    if (DUT.u_handshake_checks.error_count == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      report_problem("a bound handshake assertion failed");
    end
  end

endmodule

/* testbench/tb_mm_assertions.sv */
`timescale 1ns/1ps

module tb_mm_assertions (
  input logic CLK,
  input logic RST,
  input logic cmd_req,
  input logic cmd_ack,
  input logic rsp_req,
  input logic rsp_ack,
  input logic b_valid,
  input logic b_deq,
  input logic c_valid
);

  int error_count = 0;  // assertion failures seen

  // --------------------
  // four-phase ports
  // --------------------
  // ack stays low while no request is up
  a_cmd_ack_needs_req: assert property (@(posedge CLK) disable iff (RST)
    !cmd_ack && !cmd_req |=> !cmd_ack)
    else begin
      error_count++;
      $error("cmd_ack rose without cmd_req");
    end

  a_rsp_req_holds: assert property (@(posedge CLK) disable iff (RST)
    rsp_req && !rsp_ack |=> rsp_req)  // no withdraw before ack
    else begin
      error_count++;
      $error("rsp_req dropped before rsp_ack");
    end

  // --------------------
  // stream and reset
  // --------------------
  // dequeue only from a valid source and never with a reply outstanding
  a_deq_needs_valid: assert property (@(posedge CLK) disable iff (RST)
    b_deq |-> b_valid && !rsp_req)
    else begin
      error_count++;
      $error("b_deq high while b_valid low or a reply pending");
    end

  a_quiet_in_reset: assert property (@(posedge CLK)
    RST |=> !cmd_ack && !rsp_req && !b_deq && !c_valid)
    else begin
      error_count++;
      $error("handshake or valid output high during reset");
    end

endmodule

/* design/mm_top.sv */
`timescale 1ns/1ps
`include "mm_macros.svh"

module mm_top (
  input  logic               CLK,
  input  logic               RST,
  input  mm_pkg::a_write_t   a_write,
  input  logic               cmd_req,
  input  mm_pkg::lane_t      cmd_data,
  output logic               cmd_ack,
  input  logic               b_valid,
  input  mm_pkg::simd_word_u b_data,
  output logic               b_deq,
  output logic               c_valid,
  output mm_pkg::simd_word_u c_data,
  output logic               rsp_req,
  output mm_pkg::lane_t      rsp_data,
  input  logic               rsp_ack
);

  // --------------------
  // internal wires
  // --------------------
  logic [`MM_W_A-`MM_LOG_SIMD-1:0] ram_addr;
  mm_pkg::simd_word_u              ram_q;     // vector word, one cycle after addr
  logic                            mult_start;
  mm_pkg::simd_word_u              mult_a;
  mm_pkg::simd_word_u              mult_b;
  mm_pkg::lane_t                   matrix_size;
  logic                            new_matrix;
  mm_pkg::lane_sums_t              lane_sums;

  mm_control u_control (
    .CLK (CLK), .RST (RST),
    .cmd_req (cmd_req), .cmd_data (cmd_data), .cmd_ack (cmd_ack),
    .rsp_req (rsp_req), .rsp_data (rsp_data), .rsp_ack (rsp_ack),
    .b_valid (b_valid), .b_deq (b_deq), .b_data (b_data),
    .ram_addr (ram_addr), .ram_q (ram_q),
    .mult_start (mult_start), .mult_a (mult_a), .mult_b (mult_b),
    .matrix_size (matrix_size), .new_matrix (new_matrix)
  );

  mm_vector_ram u_vector_ram (
    .CLK (CLK), .a_write (a_write), .ram_addr (ram_addr), .ram_q (ram_q)
  );

  mm_lane_accum u_lane_accum (
    .CLK (CLK), .RST (RST),
    .mult_start (mult_start), .mult_a (mult_a), .mult_b (mult_b),
    .matrix_size (matrix_size), .new_matrix (new_matrix),
    .lane_sums (lane_sums)
  );

  mm_row_reduce u_row_reduce (
    .CLK (CLK), .RST (RST),
    .lane_sums (lane_sums), .c_valid (c_valid), .c_data (c_data)
  );

endmodule

/* design/mm_control.sv */
`timescale 1ns/1ps
`include "mm_macros.svh"

module mm_control (
  input  logic                            CLK,
  input  logic                            RST,
  input  logic                            cmd_req,
  input  mm_pkg::lane_t                   cmd_data,
  output logic                            cmd_ack,
  output logic                            rsp_req,
  output mm_pkg::lane_t                   rsp_data,
  input  logic                            rsp_ack,
  input  logic                            b_valid,
  output logic                            b_deq,
  input  mm_pkg::simd_word_u              b_data,
  output logic [`MM_W_A-`MM_LOG_SIMD-1:0] ram_addr,
  input  mm_pkg::simd_word_u              ram_q,
  output logic                            mult_start,
  output mm_pkg::simd_word_u              mult_a,
  output mm_pkg::simd_word_u              mult_b,
  output mm_pkg::lane_t                   matrix_size,
  output logic                            new_matrix
);

  localparam logic [2:0] ST_IDLE  = 3'd0;  // wait for matrix size
  localparam logic [2:0] ST_SIZE  = 3'd1;  // size handshake closing
  localparam logic [2:0] ST_CMD   = 3'd2;  // wait for computation size
  localparam logic [2:0] ST_STRM  = 3'd3;
  localparam logic [2:0] ST_TAIL  = 3'd4;  // last word being captured
  localparam logic [2:0] ST_DRAIN = 3'd5;
  localparam logic [2:0] ST_RSP   = 3'd6;

  logic [2:0]         state;
  logic [`MM_W_D-1:0] comp_size;    // stream words in this computation
  logic [`MM_W_D-1:0] deq_count;
  logic [`MM_W_D-1:0] cycle_count;
  logic [7:0]         wait_cnt;
  logic               d_deq;        // word arrives this cycle
  logic [`MM_W_D-1:0] row_words;
  logic [`MM_W_D-1:0] addr_ext;
  logic               last_addr;
  logic               last_deq;
  logic               size_take;

  // --------------------
  // stream dequeue and address wrap
  // --------------------
  assign row_words = $unsigned(matrix_size) >> `MM_LOG_SIMD;
  assign addr_ext  = {{(`MM_W_D-`MM_W_A+`MM_LOG_SIMD){1'b0}}, ram_addr};
  assign last_addr = (addr_ext == row_words - 1'b1);
  assign b_deq     = (state == ST_STRM) && b_valid && (deq_count != comp_size);
  assign last_deq  = b_deq && (deq_count + 1'b1 == comp_size);
  assign size_take = (state == ST_IDLE) && cmd_req && !cmd_ack;

  // --------------------
  // run FSM
  // --------------------
  always_ff @(posedge CLK) begin
    if (RST) begin
      state       <= ST_IDLE;
      cmd_ack     <= 1'b0;
      rsp_req     <= 1'b0;
      new_matrix  <= 1'b0;
      comp_size   <= '0;
      deq_count   <= '0;
      wait_cnt    <= '0;
      ram_addr    <= '0;
      matrix_size <= '0;
    end else begin
      new_matrix <= 1'b0;
      if (cmd_ack && !cmd_req) begin
        cmd_ack <= 1'b0;  // requester let go
      end
      if (b_deq) begin
        deq_count <= deq_count + 1'b1;
        ram_addr  <= last_addr ? '0 : ram_addr + 1'b1;  // next vector word
      end
      case (state)
        ST_IDLE: begin
          if (size_take) begin
            matrix_size <= cmd_data;
            cmd_ack     <= 1'b1;
            new_matrix  <= 1'b1;  // clears the sums downstream
            ram_addr    <= '0;
            state       <= ST_SIZE;
          end
        end
        ST_SIZE: begin
          if (!cmd_req) begin
            state <= ST_CMD;
          end
        end
        ST_CMD: begin
          if (cmd_req && !cmd_ack) begin
            cmd_ack   <= 1'b1;
            comp_size <= cmd_data;
            deq_count <= '0;
            state     <= (cmd_data == '0) ? ST_IDLE : ST_STRM;  // zero ends the matrix
          end
        end
        ST_STRM: begin
          if (last_deq) begin
            state <= ST_TAIL;
          end
        end
        ST_TAIL: begin
          wait_cnt <= '0;
          state    <= ST_DRAIN;
        end
        ST_DRAIN: begin
          wait_cnt <= wait_cnt + 1'b1;
          if (wait_cnt == `MM_DRAIN) begin
            rsp_req <= 1'b1;
            state   <= ST_RSP;
          end
        end
        ST_RSP: begin
          if (rsp_req && rsp_ack) begin
            rsp_req <= 1'b0;
          end else if (!rsp_req && !rsp_ack) begin
            state <= ST_CMD;  // four-phase done
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // capture strobe, one cycle behind the dequeue
  always_ff @(posedge CLK) begin
    if (RST) begin
      d_deq      <= 1'b0;
      mult_start <= 1'b0;
    end else begin
      d_deq      <= b_deq;
      mult_start <= d_deq;
    end
  end

  always_ff @(posedge CLK) begin
    if (d_deq) begin
      mult_a <= ram_q;   // vector word
      mult_b <= b_data;  // matrix word
    end
    if (state == ST_DRAIN && wait_cnt == `MM_DRAIN) begin
      rsp_data <= cycle_count;
    end
  end

  // cycles since the matrix size came in
  always_ff @(posedge CLK) begin
    if (RST || size_take) begin
      cycle_count <= '0;
    end else begin
      cycle_count <= cycle_count + 1'b1;
    end
  end

endmodule

/* design/mm_row_reduce.sv */
`timescale 1ns/1ps
`include "mm_macros.svh"

module mm_row_reduce (
  input  logic               CLK,
  input  logic               RST,
  input  mm_pkg::lane_sums_t lane_sums,
  output logic               c_valid,
  output mm_pkg::simd_word_u c_data
);

  mm_pkg::lane_t         row_sum;
  logic                  row_valid;
  logic [`MM_LOG_SIMD:0] pack_cnt;   // rows already in the word
  logic                  word_full;

  // --------------------
  // adder tree
  // --------------------
  if (`MM_LOG_SIMD == 0) begin : g_single
    mm_pkg::lane_t sum_q;
    logic          vld_q;
    always_ff @(posedge CLK) begin
      sum_q <= lane_sums.sums.lanes[0];  // one lane, just a register
    end
    always_ff @(posedge CLK) begin
      if (RST) begin
        vld_q <= 1'b0;
      end else begin
        vld_q <= lane_sums.valid;
      end
    end
    assign row_sum   = sum_q;
    assign row_valid = vld_q;
  end else begin : g_tree
    for (genvar l = 0; l < `MM_LOG_SIMD; l++) begin : g_lvl
      localparam int NODES = `MM_SIMD_WIDTH >> (l + 1);
      mm_pkg::lane_t [2*NODES-1:0] src;
      logic                        src_vld;
      mm_pkg::lane_t [NODES-1:0]   sum_q;
      logic                        vld_q;
      if (l == 0) begin : g_src_in
        assign src     = lane_sums.sums.lanes;
        assign src_vld = lane_sums.valid;
      end else begin : g_src_prev
        assign src     = g_lvl[l-1].sum_q;  // previous level
        assign src_vld = g_lvl[l-1].vld_q;
      end
      always_ff @(posedge CLK) begin
        for (int j = 0; j < NODES; j++) begin
          sum_q[j] <= src[2*j] + src[2*j+1];  // pairwise
        end
      end
      always_ff @(posedge CLK) begin
        if (RST) begin
          vld_q <= 1'b0;
        end else begin
          vld_q <= src_vld;
        end
      end
    end
    assign row_sum   = g_lvl[`MM_LOG_SIMD-1].sum_q[0];
    assign row_valid = g_lvl[`MM_LOG_SIMD-1].vld_q;
  end

  // --------------------
  // pack rows into output words
  // --------------------
  assign word_full = (pack_cnt == `MM_SIMD_WIDTH - 1);

  always_ff @(posedge CLK) begin
    if (RST) begin
      pack_cnt <= '0;
      c_valid  <= 1'b0;
    end else begin
      c_valid <= row_valid && word_full;  // every SIMD_WIDTH-th row
      if (row_valid) begin
        pack_cnt <= word_full ? '0 : pack_cnt + 1'b1;
      end
    end
  end

  // shift down, newest row in the top lane
  always_ff @(posedge CLK) begin
    if (row_valid) begin
      for (int k = 0; k < `MM_SIMD_WIDTH - 1; k++) begin
        c_data.lanes[k] <= c_data.lanes[k+1];
      end
      c_data.lanes[`MM_SIMD_WIDTH-1] <= row_sum;
    end
  end

endmodule

/* design/mm_lane_accum.sv */
`timescale 1ns/1ps
`include "mm_macros.svh"

module mm_lane_accum (
  input  logic               CLK,
  input  logic               RST,
  input  logic               mult_start,
  input  mm_pkg::simd_word_u mult_a,
  input  mm_pkg::simd_word_u mult_b,
  input  mm_pkg::lane_t      matrix_size,
  input  logic               new_matrix,
  output mm_pkg::lane_sums_t lane_sums
);

  mm_pkg::product_t          prod [`MM_SIMD_WIDTH];
  logic [`MM_SIMD_WIDTH-1:0] prod_vld;
  mm_pkg::lane_t             acc [`MM_SIMD_WIDTH];  // running row sums
  logic [`MM_W_D-1:0]        elem_count;             // elements done in this row
  logic                      step;
  logic                      row_end;
  logic                      sum_vld;
  mm_pkg::simd_word_u        sums_q;

  // --------------------
  // one multiplier per lane
  // --------------------
  for (genvar i = 0; i < `MM_SIMD_WIDTH; i++) begin : g_lane
    mm_multiplier u_mult (
      .CLK   (CLK),
      .RST   (RST),
      .in_a  (mult_a.lanes[i]),
      .in_b  (mult_b.lanes[i]),
      .start (mult_start),
      .rslt  (prod[i]),
      .valid (prod_vld[i])
    );
  end

  assign step    = &prod_vld;  // lanes run in lockstep
  assign row_end = (elem_count + `MM_SIMD_WIDTH >= $unsigned(matrix_size));

  always_ff @(posedge CLK) begin
    if (RST || new_matrix) begin
      elem_count <= '0;
      sum_vld    <= 1'b0;
      for (int j = 0; j < `MM_SIMD_WIDTH; j++) begin
        acc[j] <= '0;
      end
    end else begin
      sum_vld <= step && row_end;
      if (step) begin
        elem_count <= row_end ? '0 : elem_count + `MM_SIMD_WIDTH;
        for (int j = 0; j < `MM_SIMD_WIDTH; j++) begin
          // low word only, 32-bit wraparound
          acc[j] <= row_end ? '0 : acc[j] + prod[j][`MM_W_D-1:0];
        end
      end
    end
  end

  // finished sums, held until the next row ends
  always_ff @(posedge CLK) begin
    if (step && row_end) begin
      for (int j = 0; j < `MM_SIMD_WIDTH; j++) begin
        sums_q.lanes[j] <= acc[j] + prod[j][`MM_W_D-1:0];
      end
    end
  end

  assign lane_sums.valid = sum_vld;
  assign lane_sums.sums  = sums_q;

endmodule

/* design/mm_multiplier.sv */
`timescale 1ns/1ps
`include "mm_macros.svh"

module mm_multiplier (
  input  logic             CLK,
  input  logic             RST,
  input  mm_pkg::lane_t    in_a,
  input  mm_pkg::lane_t    in_b,
  input  logic             start,
  output mm_pkg::product_t rslt,
  output logic             valid
);

  // product register plus plain delay stages
  localparam int MAG_STAGES = `MM_MULT_DEPTH - 1;

  logic [`MM_W_D-1:0]   mag_a;
  logic [`MM_W_D-1:0]   mag_b;
  logic [2*`MM_W_D-1:0] mag_pipe [MAG_STAGES];
  logic [`MM_MULT_DEPTH-1:0] neg_sr;  // product sign, per stage
  logic [`MM_MULT_DEPTH:0]   vld_sr;

  // --------------------
  // magnitude datapath
  // --------------------
  always_ff @(posedge CLK) begin
    // most negative input maps to 2**31, still fits unsigned
    mag_a  <= in_a[`MM_W_D-1] ? $unsigned(-in_a) : $unsigned(in_a);
    mag_b  <= in_b[`MM_W_D-1] ? $unsigned(-in_b) : $unsigned(in_b);
    neg_sr <= {neg_sr[`MM_MULT_DEPTH-2:0], in_a[`MM_W_D-1] ^ in_b[`MM_W_D-1]};
    mag_pipe[0] <= {{`MM_W_D{1'b0}}, mag_a} * {{`MM_W_D{1'b0}}, mag_b};
    for (int k = 1; k < MAG_STAGES; k++) begin
      mag_pipe[k] <= mag_pipe[k-1];
    end
    // sign restored on the way out
    if (neg_sr[`MM_MULT_DEPTH-1]) begin
      rslt <= -$signed(mag_pipe[MAG_STAGES-1]);
    end else begin
      rslt <= $signed(mag_pipe[MAG_STAGES-1]);
    end
  end

  // --------------------
  // valid tracks the data, depth+1 cycles
  // --------------------
  always_ff @(posedge CLK) begin
    if (RST) begin
      vld_sr <= '0;
    end else begin
      vld_sr <= {vld_sr[`MM_MULT_DEPTH-1:0], start};
    end
  end

  assign valid = vld_sr[`MM_MULT_DEPTH];

endmodule

/* design/mm_vector_ram.sv */
`timescale 1ns/1ps
`include "mm_macros.svh"

module mm_vector_ram (
  input  logic                            CLK,
  input  mm_pkg::a_write_t                a_write,
  input  logic [`MM_W_A-`MM_LOG_SIMD-1:0] ram_addr,
  output mm_pkg::simd_word_u              ram_q
);

  localparam int DEPTH = 2 ** (`MM_W_A - `MM_LOG_SIMD);  // words

  mm_pkg::simd_word_u mem [DEPTH];

  // --------------------
  // one write port, one registered read
  // --------------------
  always_ff @(posedge CLK) begin
    if (a_write.we) begin
      mem[a_write.addr] <= a_write.data;  // loaded while idle
    end
    ram_q <= mem[ram_addr];  // old data on a same-address write
  end

endmodule

/* design/mm_pkg.sv */
`include "mm_macros.svh"

package mm_pkg;

  // --------------------
  // data words
  // --------------------
  typedef logic signed [`MM_W_D-1:0] lane_t;  // one element

  // one stream or vector word, seen whole or per lane
  typedef union packed {
    logic [`MM_SIMD_WIDTH*`MM_W_D-1:0] flat;
    lane_t [`MM_SIMD_WIDTH-1:0]         lanes;  // lane 0 in the low bits
  } simd_word_u;

  typedef logic signed [2*`MM_W_D-1:0] product_t;  // full width product

  // --------------------
  // transfers
  // --------------------
  typedef struct packed {
    logic                                we;
    logic [`MM_W_A-`MM_LOG_SIMD-1:0]     addr;  // word address
    simd_word_u                          data;
  } a_write_t;

  // finished row sums, one per lane
  typedef struct packed {
    logic       valid;
    simd_word_u sums;
  } lane_sums_t;

endpackage

/* design/mm_macros.svh */
`ifndef MM_MACROS_SVH
`define MM_MACROS_SVH

// --------------------
// lane geometry
// --------------------
`define MM_SIMD_WIDTH 2  // elements per stream word
`define MM_LOG_SIMD   1  // log2 of lane count

// element and address widths
`define MM_W_D 32  // one signed element
`define MM_W_A 9   // vector address in elements

// --------------------
// pipeline timing
// --------------------
`define MM_MULT_DEPTH 6  // multiplier stages, latency is one more

// cycles waited after the last capture before replying
// covers multiplier, accumulate, tree and packing
`define MM_DRAIN (`MM_MULT_DEPTH + 2 + `MM_SIMD_WIDTH + 1)

`endif
